// ==== Bender.yml ====
package:
  name: compute_unit

sources:
  - hw/rv32_pkg.sv
  - hw/compute_pkg.sv
  - hw/inst_mem.sv
  - hw/decode.sv
  - hw/execute.sv
  - hw/result.sv
  - hw/compute_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_compute.sv

// ==== all.f ====
hw/rv32_pkg.sv
hw/compute_pkg.sv
hw/inst_mem.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/compute_top.sv
bench/clock_gen.sv
bench/tb_compute.sv

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset is held for eight rising edges and released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/tb_compute.sv ====
`timescale 1ns/1ps

module tb_compute;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        load_valid;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        reg_valid;
    logic [4:0]  reg_addr;
    logic        load_ready;
    logic        reg_ready;
    logic [31:0] reg_data;
    logic        finished_flag;
    logic        faulted_flag;

    logic [31:0] prog[$];
    logic [31:0] model [32];
    logic [31:0] lcg_state = 32'h035d_6245;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    clock_gen clk0 (.clk, .rst_n);

    compute_top dut0 (
        .clk, .rst_n, .start,
        .load_valid, .load_addr, .load_data,
        .reg_valid, .reg_addr,
        .load_ready, .reg_ready, .reg_data,
        .finished_flag, .faulted_flag
    );

    // Both host ports follow the same idle condition
    assert property (@(posedge clk) disable iff (!rst_n) load_ready == reg_ready)
        else begin
            errors++;
            $display("load_ready and reg_ready disagree");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(finished_flag && faulted_flag))
        else begin
            errors++;
            $display("finished_flag and faulted_flag are high together");
        end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                               logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    // Offset is in bytes, as the branch instruction encodes it
    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                                logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // The addi adds a sign-extended low part, so the upper part absorbs bit 11
    function automatic void push_const(logic [4:0] rd, logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + 20'(value[11]);
        prog.push_back(lui_word(rd, upper));
        prog.push_back(addi_word(rd, rd, value[11:0]));
        if (rd != 5'd0) begin
            model[rd] = value;
        end
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic load_program();
        int waited;
        for (int i = 0; i < prog.size(); i++) begin
            load_valid <= 1'b1;
            load_addr  <= 8'(i);
            load_data  <= prog[i];
            waited = 0;
            @(negedge clk);
            while (!load_ready) begin
                waited++;
                if (waited > 100) stop_on_timeout("the program load to be accepted");
                @(negedge clk);
            end
            @(posedge clk);
        end
        load_valid <= 1'b0;
        prog.delete();
    endtask

    task automatic run_program(input string name, input logic want_finish, output int busy);
        busy = 0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!finished_flag && !faulted_flag) begin
            assert (!load_ready && !reg_ready) else begin
                errors++;
                $display("%s: host ports were ready while the core was running", name);
            end
            busy++;
            if (busy > 5000) stop_on_timeout("the core to finish or fault");
            @(negedge clk);
        end
        checks += 3;
        assert (load_ready && reg_ready) else begin
            errors++;
            $display("%s: host ports stayed low after the flag rose", name);
        end
        assert (finished_flag == want_finish) else begin
            errors++;
            $display("error %s: finished_flag expected %0b, actual %0b",
                     name, want_finish, finished_flag);
        end
        assert (faulted_flag == !want_finish) else begin
            errors++;
            $display("error %s: faulted_flag expected %0b, actual %0b",
                     name, !want_finish, faulted_flag);
        end
        @(posedge clk);
    endtask

    task automatic read_reg(input logic [4:0] idx, output logic [31:0] value);
        int waited;
        reg_valid <= 1'b1;
        reg_addr  <= idx;
        waited = 0;
        @(negedge clk);
        while (!reg_ready) begin
            waited++;
            if (waited > 100) stop_on_timeout("the register read to be accepted");
            @(negedge clk);
        end
        value = reg_data;
        @(posedge clk);
        reg_valid <= 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [4:0] idx);
        logic [31:0] value;
        read_reg(idx, value);
        checks++;
        assert (value == model[idx]) else begin
            errors++;
            $display("error %s: x%0d expected %h, actual %h", name, idx, model[idx], value);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail with %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        int          mark;
        int          busy;
        int          waited;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] n;

        start      <= 1'b0;
        load_valid <= 1'b0;
        load_addr  <= '0;
        load_data  <= '0;
        reg_valid  <= 1'b0;
        reg_addr   <= '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end

        waited = 0;
        @(posedge clk);
        while (!rst_n) begin
            waited++;
            if (waited > 100) stop_on_timeout("reset release");
            @(posedge clk);
        end
        @(posedge clk);

        mark = errors;
        checks++;
        assert (load_ready && reg_ready && !finished_flag && !faulted_flag) else begin
            errors++;
            $display("reset_state: ports or flags wrong after reset");
        end
        check_reg("reset_state", 5'd5);
        check_reg("reset_state", 5'd31);
        report_test("reset_state", mark);

        mark = errors;
        for (int i = 1; i <= 8; i++) begin
            a = next_random();
            imm = a[27:16];
            prog.push_back(addi_word(5'(i), 5'(i - 1), imm));
            model[i] = model[i - 1] + {{20{imm[11]}}, imm};
        end
        prog.push_back(32'h0000_0073);
        load_program();
        run_program("addi_chain", 1'b1, busy);
        for (int i = 1; i <= 8; i++) begin
            check_reg("addi_chain", 5'(i));
        end
        report_test("addi_chain", mark);

        mark = errors;
        a = next_random();
        b = next_random();
        push_const(5'd10, a);
        push_const(5'd11, b);
        prog.push_back(rtype_word(7'b0000000, 5'd11, 5'd10, 5'd12));
        prog.push_back(rtype_word(7'b0100000, 5'd11, 5'd10, 5'd13));
        prog.push_back(rtype_word(7'b0100000, 5'd10, 5'd11, 5'd14));
        prog.push_back(32'h0000_0073);
        model[12] = a + b;
        model[13] = a - b;
        model[14] = b - a;
        load_program();
        run_program("add_sub", 1'b1, busy);
        for (int i = 10; i <= 14; i++) begin
            check_reg("add_sub", 5'(i));
        end
        report_test("add_sub", mark);

        // Writes aimed at x0 must leave it reading zero
        mark = errors;
        push_const(5'd15, next_random());
        prog.push_back(addi_word(5'd0, 5'd0, 12'h123));
        prog.push_back(lui_word(5'd0, 20'hABCDE));
        prog.push_back(32'h0000_0073);
        load_program();
        run_program("lui_const", 1'b1, busy);
        check_reg("lui_const", 5'd15);
        check_reg("lui_const", 5'd0);
        report_test("lui_const", mark);

        mark = errors;
        n = (next_random() >> 16) % 20 + 1;
        prog.push_back(addi_word(5'd20, 5'd0, 12'd0));
        prog.push_back(addi_word(5'd21, 5'd0, n[11:0]));
        prog.push_back(addi_word(5'd20, 5'd20, 12'd1));
        prog.push_back(branch_word(3'b001, 5'd20, 5'd21, -13'sd4));
        prog.push_back(branch_word(3'b000, 5'd20, 5'd21, 13'sd8));
        prog.push_back(addi_word(5'd22, 5'd0, 12'd1));
        prog.push_back(32'h0000_0073);
        model[20] = n;
        model[21] = n;
        load_program();
        run_program("branch_loop", 1'b1, busy);
        check_reg("branch_loop", 5'd20);
        check_reg("branch_loop", 5'd22);
        report_test("branch_loop", mark);

        mark = errors;
        a = next_random();
        prog.push_back(addi_word(5'd23, 5'd0, a[23:12]));
        prog.push_back(32'h0000_0000);
        prog.push_back(addi_word(5'd1, 5'd0, 12'd7));
        model[23] = {{20{a[23]}}, a[23:12]};
        load_program();
        run_program("illegal_word", 1'b0, busy);
        check_reg("illegal_word", 5'd23);
        check_reg("illegal_word", 5'd1);
        check_reg("illegal_word", 5'd12);
        report_test("illegal_word", mark);

        // Two instructions keep the core busy for three cycles each
        mark = errors;
        prog.push_back(addi_word(5'd24, 5'd0, 12'd9));
        prog.push_back(32'h0000_0073);
        model[24] = 32'd9;
        load_program();
        run_program("ready_while_busy", 1'b1, busy);
        checks++;
        assert (busy == 6) else begin
            errors++;
            $display("error ready_while_busy: busy cycles expected 6, actual %0d", busy);
        end
        check_reg("ready_while_busy", 5'd24);
        report_test("ready_while_busy", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/compute_pkg.sv ====
package compute_pkg;

    localparam int mem_depth = 256;

    // Word address into the instruction memory
    localparam int pc_width = 8;

    localparam logic [pc_width-1:0] start_addr = '0;

    // Each instruction walks through fetch, decode and commit once
    typedef enum logic [1:0] {
        phase_idle,
        phase_fetch,
        phase_decode,
        phase_commit
    } phase_t;

endpackage

// ==== hw/compute_top.sv ====
`timescale 1ns/1ps

module compute_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic                             load_valid,
    input  logic [compute_pkg::pc_width-1:0] load_addr,
    input  logic [31:0]                      load_data,
    input  logic                             reg_valid,
    input  logic [4:0]                       reg_addr,
    output logic                             load_ready,
    output logic                             reg_ready,
    output logic [31:0]                      reg_data,
    output logic                             finished_flag,
    output logic                             faulted_flag
);

    import compute_pkg::*;
    import rv32_pkg::*;

    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] next_pc;
    phase_t              phase;
    logic                fetch_en;
    logic                capture;
    logic [31:0]         fetch_data;

    alu_op_t         alu_op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            wr_en;
    logic            is_branch;
    logic            branch_ne;
    logic            is_ecall;
    logic            illegal;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] alu_result;

    inst_mem inst_mem_inst (
        .clk, .rst_n,
        .load_valid, .load_addr, .load_data, .load_ready,
        .fetch_en, .fetch_addr(pc), .fetch_data
    );

    decode decode_inst (
        .clk, .rst_n,
        .capture, .inst_word(fetch_data),
        .alu_op, .rs1, .rs2, .rd, .imm, .use_imm, .wr_en,
        .is_branch, .branch_ne, .is_ecall, .illegal
    );

    execute execute_inst (
        .alu_op, .use_imm, .imm, .rs1_val, .rs2_val,
        .is_branch, .branch_ne, .pc,
        .alu_result, .next_pc
    );

    result result_inst (
        .clk, .rst_n, .start,
        .alu_result, .next_pc, .wr_en, .rd, .rs1, .rs2, .is_ecall, .illegal,
        .reg_addr, .pc, .phase, .fetch_en, .capture, .rs1_val, .rs2_val,
        .reg_data, .load_ready, .reg_ready, .finished_flag, .faulted_flag
    );

    // A register read that arrives mid-run waits for the core to stop
    assert property (@(posedge clk) disable iff (!rst_n)
        (reg_valid && phase != phase_idle) |=> reg_valid)
        else $error("register read dropped before it was accepted");

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      capture,
    input  logic [31:0]               inst_word,
    output rv32_pkg::alu_op_t         alu_op,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd,
    output logic [rv32_pkg::xlen-1:0] imm,
    output logic                      use_imm,
    output logic                      wr_en,
    output logic                      is_branch,
    output logic                      branch_ne,
    output logic                      is_ecall,
    output logic                      illegal
);

    import rv32_pkg::*;

    rv32_inst_t inst_q;

    // Holds a nop until the first real fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_q <= inst_nop;
        end else if (capture) begin
            inst_q <= inst_word;
        end
    end

    assign rs1 = inst_q.r.rs1;
    assign rs2 = inst_q.r.rs2;
    assign rd  = inst_q.r.rd;

    always_comb begin
        alu_op    = alu_add;
        imm       = '0;
        use_imm   = 1'b0;
        wr_en     = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_ecall  = 1'b0;
        illegal   = 1'b0;

        case (inst_q.r.opcode)
            opc_op: begin
                if (inst_q.r.funct3 == f3_add && inst_q.r.funct7 == '0) begin
                    wr_en = 1'b1;
                end else if (inst_q.r.funct3 == f3_add && inst_q.r.funct7 == f7_sub) begin
                    alu_op = alu_sub;
                    wr_en  = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_op_imm: begin
                imm = {{20{inst_q.i.imm12[11]}}, inst_q.i.imm12};
                if (inst_q.i.funct3 == f3_add) begin
                    use_imm = 1'b1;
                    wr_en   = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_lui: begin
                // Upper 20 bits of the word sit where imm12, rs1 and funct3 are
                imm     = {inst_q.i.imm12, inst_q.i.rs1, inst_q.i.funct3, 12'b0};
                alu_op  = alu_pass_b;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            opc_branch: begin
                imm = {{19{inst_q.b.imm_12}}, inst_q.b.imm_12, inst_q.b.imm_11,
                       inst_q.b.imm_10_5, inst_q.b.imm_4_1, 1'b0};
                if (inst_q.b.funct3 == f3_beq) begin
                    is_branch = 1'b1;
                end else if (inst_q.b.funct3 == f3_bne) begin
                    is_branch = 1'b1;
                    branch_ne = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_system: begin
                // Only the plain ecall encoding, ebreak and csr ops fault
                if (inst_q.i.imm12 == '0 && inst_q.i.rs1 == '0 &&
                    inst_q.i.funct3 == '0 && inst_q.i.rd == '0) begin
                    is_ecall = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // A fetch past the loaded program returns an undefined word
    assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> !$isunknown(inst_word))
        else $error("captured an undefined instruction word");

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/1ps

module execute (
    input  rv32_pkg::alu_op_t                alu_op,
    input  logic                             use_imm,
    input  logic [rv32_pkg::xlen-1:0]        imm,
    input  logic [rv32_pkg::xlen-1:0]        rs1_val,
    input  logic [rv32_pkg::xlen-1:0]        rs2_val,
    input  logic                             is_branch,
    input  logic                             branch_ne,
    input  logic [compute_pkg::pc_width-1:0] pc,
    output logic [rv32_pkg::xlen-1:0]        alu_result,
    output logic [compute_pkg::pc_width-1:0] next_pc
);

    import rv32_pkg::*;

    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] word_offset;
    logic            taken;

    assign operand_b = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = rs1_val + operand_b;
            alu_sub:    alu_result = rs1_val - operand_b;
            alu_pass_b: alu_result = operand_b;
            default:    alu_result = operand_b;
        endcase
    end

    // The pc counts words, so the byte offset drops its two low bits
    assign word_offset = {{2{imm[xlen-1]}}, imm[xlen-1:2]};

    assign taken = is_branch && ((rs1_val == rs2_val) != branch_ne);

    always_comb begin
        if (taken) begin
            next_pc = pc + word_offset[$bits(next_pc)-1:0];
        end else begin
            next_pc = pc + 1'b1;
        end
    end

    always_comb begin
        if (is_branch) begin
            assert final (imm[1:0] == 2'b00)
                else $error("branch offset is not word aligned");
        end
    end

endmodule

// ==== hw/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_valid,
    input  logic [compute_pkg::pc_width-1:0] load_addr,
    input  logic [31:0]                     load_data,
    input  logic                            load_ready,
    input  logic                            fetch_en,
    input  logic [compute_pkg::pc_width-1:0] fetch_addr,
    output logic [31:0]                     fetch_data
);

    import compute_pkg::*;

    logic [31:0] mem [mem_depth];

    always_ff @(posedge clk) begin
        if (load_valid && load_ready) begin
            mem[load_addr] <= load_data;
        end
    end

    // Word shows up one cycle after the fetch strobe
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data <= mem[fetch_addr];
        end
    end

    // The host may only write while the core is stopped
    assert property (@(posedge clk) disable iff (!rst_n)
        !(load_valid && load_ready && fetch_en))
        else $error("instruction memory written during a fetch");

endmodule

// ==== hw/result.sv ====
`timescale 1ns/1ps

module result (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [31:0]                      alu_result,
    input  logic [compute_pkg::pc_width-1:0] next_pc,
    input  logic                             wr_en,
    input  logic [4:0]                       rd,
    input  logic [4:0]                       rs1,
    input  logic [4:0]                       rs2,
    input  logic                             is_ecall,
    input  logic                             illegal,
    input  logic [4:0]                       reg_addr,
    output logic [compute_pkg::pc_width-1:0] pc,
    output compute_pkg::phase_t              phase,
    output logic                             fetch_en,
    output logic                             capture,
    output logic [31:0]                      rs1_val,
    output logic [31:0]                      rs2_val,
    output logic [31:0]                      reg_data,
    output logic                             load_ready,
    output logic                             reg_ready,
    output logic                             finished_flag,
    output logic                             faulted_flag
);

    import compute_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase         <= phase_idle;
            pc            <= start_addr;
            finished_flag <= 1'b0;
            faulted_flag  <= 1'b0;
        end else begin
            case (phase)
                phase_idle: begin
                    if (start) begin
                        phase         <= phase_fetch;
                        pc            <= start_addr;
                        finished_flag <= 1'b0;
                        faulted_flag  <= 1'b0;
                    end
                end
                phase_fetch: begin
                    phase <= phase_decode;
                end
                phase_decode: begin
                    phase <= phase_commit;
                end
                phase_commit: begin
                    if (illegal) begin
                        faulted_flag <= 1'b1;
                        phase        <= phase_idle;
                    end else if (is_ecall) begin
                        finished_flag <= 1'b1;
                        phase         <= phase_idle;
                    end else begin
                        pc    <= next_pc;
                        phase <= phase_fetch;
                    end
                end
                default: begin
                    phase <= phase_idle;
                end
            endcase
        end
    end

    // Entry zero is never written, so x0 keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (phase == phase_commit && wr_en && rd != '0) begin
            regs[rd] <= alu_result;
        end
    end

    assign rs1_val  = regs[rs1];
    assign rs2_val  = regs[rs2];
    assign reg_data = regs[reg_addr];

    assign fetch_en   = (phase == phase_fetch);
    assign capture    = (phase == phase_decode);
    assign load_ready = (phase == phase_idle);
    assign reg_ready  = (phase == phase_idle);

    // A committed word either finishes or faults, never both
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase == phase_commit) |-> !(illegal && is_ecall))
        else $error("committed word decoded as both ecall and illegal");

endmodule

// ==== hw/rv32_pkg.sv ====
package rv32_pkg;

    localparam int xlen = 32;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] inst_nop = 32'h0000_0013;

    // One instruction word seen through the R, I and B formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } rv32_inst_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b
    } alu_op_t;

endpackage
